// ==== design/flow_arb_rr.sv ====
// Round-robin ready-valid arbiter with zero latency. NumFlows must be at least 2
`timescale 1ns/1ps
`default_nettype none

module flow_arb_rr #(
  parameter int NumFlows = 4
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [NumFlows-1:0] push_valid,
  output logic [NumFlows-1:0] push_ready,
  input  logic                pop_ready,
  output logic                pop_valid
);

  localparam int IdxW = $clog2(NumFlows);

  // --------------------------------------------------
  // Priority pointer
  // --------------------------------------------------
  // One-hot, marks the requester with top priority
  logic [NumFlows-1:0]   ptr_q;
  logic [IdxW-1:0]       ptr_idx;

  // Request and grant in pointer-relative order
  logic [2*NumFlows-1:0] req_dbl;
  logic [NumFlows-1:0]   req_rot;
  logic [NumFlows-1:0]   gnt_rot;
  logic [2*NumFlows-1:0] gnt_dbl;
  logic [NumFlows-1:0]   grant;

  // Binary position of the pointer bit
  always_comb begin
    ptr_idx = '0;
    for (int i = 0; i < NumFlows; i++) begin
      if (ptr_q[i]) begin
        ptr_idx = IdxW'(i);
      end
    end
  end

  // --------------------------------------------------
  // Grant selection
  // --------------------------------------------------
  // Rotate right so the pointer bit lands on bit 0
  assign req_dbl = {push_valid, push_valid} >> ptr_idx;
  assign req_rot = req_dbl[NumFlows-1:0];

  // Lowest set bit wins, i.e. first valid at or after the pointer
  assign gnt_rot = req_rot & (~req_rot + NumFlows'(1));

  // Rotate left by the same amount to get back to requester order
  assign gnt_dbl = {gnt_rot, gnt_rot} << ptr_idx;
  assign grant   = gnt_dbl[2*NumFlows-1:NumFlows];

  // Winner sees ready only when the consumer takes the beat
  assign push_ready = grant & {NumFlows{pop_ready}};
  assign pop_valid  = |push_valid;

  // --------------------------------------------------
  // Pointer update
  // --------------------------------------------------
  // Move one past the winner on a completed pop
  // A stalled grant keeps its turn
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr_q <= NumFlows'(1);
    end else if (pop_valid && pop_ready) begin
      ptr_q <= {grant[NumFlows-2:0], grant[NumFlows-1]};
    end
  end

endmodule

`default_nettype wire

// ==== design/flow_lane_merge.sv ====
// Two-lane merger with registered output. Assumes NUM_LANES is 2 so the lane tag is one bit
`timescale 1ns/1ps
`default_nettype none

`include "flow_mux_cfg.svh"

module flow_lane_merge (
  input  logic                                      clk,
  input  logic                                      arst_n,
  input  logic [`NUM_LANES-1:0]                     lane_valid,
  output logic [`NUM_LANES-1:0]                     lane_ready,
  input  flow_mux_pkg::lane_beat_t [`NUM_LANES-1:0] lane_beat,
  input  logic                                      pop_ready,
  output logic                                      pop_valid,
  output flow_mux_pkg::out_beat_t                   pop_beat
);

  // Lane arbitration
  logic                      arb_valid;
  logic                      not_full_q;
  logic                      lane_sel;
  logic                      push_en;
  flow_mux_pkg::out_beat_t   in_beat;

  // Skid buffer
  flow_mux_pkg::skid_state_e state_q;
  flow_mux_pkg::skid_state_e state_d;
  flow_mux_pkg::out_beat_t   head_q;
  flow_mux_pkg::out_beat_t   tail_q;
  logic                      pop_en;

  // --------------------------------------------------
  // Lane arbitration
  // --------------------------------------------------
  // Consumer side is the registered not-full flag
  // No path from pop_ready back to the lanes
  flow_arb_rr #(
    .NumFlows(`NUM_LANES)
  ) lane_arb_i (
    .clk,
    .arst_n,
    .push_valid(lane_valid),
    .push_ready(lane_ready),
    .pop_ready (not_full_q),
    .pop_valid (arb_valid)
  );

  assign push_en  = arb_valid && not_full_q;

  // Grant is one-hot so bit 1 alone names the lane
  assign lane_sel = lane_ready[1];

  // Lane bit goes above the lane-local index
  always_comb begin
    in_beat.src  = {lane_sel, lane_beat[lane_sel].idx};
    in_beat.data = lane_beat[lane_sel].data;
  end

  // --------------------------------------------------
  // Skid buffer control
  // --------------------------------------------------
  assign pop_valid = (state_q != flow_mux_pkg::SKID_EMPTY);
  assign pop_en    = pop_valid && pop_ready;
  assign pop_beat  = head_q;

  // Push with pop keeps the level
  always_comb begin
    state_d = state_q;
    case (state_q)
      flow_mux_pkg::SKID_EMPTY: begin
        if (push_en) begin
          state_d = flow_mux_pkg::SKID_ONE;
        end
      end
      flow_mux_pkg::SKID_ONE: begin
        if (push_en && !pop_en) begin
          state_d = flow_mux_pkg::SKID_TWO;
        end else if (!push_en && pop_en) begin
          state_d = flow_mux_pkg::SKID_EMPTY;
        end
      end
      flow_mux_pkg::SKID_TWO: begin
        // Lanes are blocked here so only a pop can happen
        if (pop_en) begin
          state_d = flow_mux_pkg::SKID_ONE;
        end
      end
      default: begin
        state_d = flow_mux_pkg::SKID_EMPTY;
      end
    endcase
  end

  // Not-full stays low through reset and rises on the first edge after it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q    <= flow_mux_pkg::SKID_EMPTY;
      not_full_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      not_full_q <= (state_d != flow_mux_pkg::SKID_TWO);
    end
  end

  // --------------------------------------------------
  // Skid buffer storage
  // --------------------------------------------------
  // Head always holds the oldest beat
  always_ff @(posedge clk) begin
    if (state_q == flow_mux_pkg::SKID_EMPTY) begin
      if (push_en) begin
        head_q <= in_beat;
      end
    end else if (state_q == flow_mux_pkg::SKID_ONE) begin
      if (push_en && pop_en) begin
        head_q <= in_beat;
      end else if (push_en) begin
        tail_q <= in_beat;
      end
    end else if (state_q == flow_mux_pkg::SKID_TWO) begin
      // Older second entry moves up
      if (pop_en) begin
        head_q <= tail_q;
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/flow_merge_top.sv ====
// Eight-input round-robin merger with one-cycle registered output. Lane 0 owns inputs 0 to 3
`timescale 1ns/1ps
`default_nettype none

`include "flow_mux_cfg.svh"

module flow_merge_top (
  input  logic                                                     clk,
  input  logic                                                     arst_n,
  input  logic [`NUM_LANES*`FLOWS_PER_LANE-1:0]                    push_valid,
  output logic [`NUM_LANES*`FLOWS_PER_LANE-1:0]                    push_ready,
  input  logic [`NUM_LANES*`FLOWS_PER_LANE-1:0][`DATA_WIDTH-1:0]   push_data,
  input  logic                                                     pop_ready,
  output logic                                                     pop_valid,
  output flow_mux_pkg::out_beat_t                                  pop_beat
);

  // Lane multiplexer outputs toward the merger
  logic [`NUM_LANES-1:0]                     lane_valid;
  logic [`NUM_LANES-1:0]                     lane_ready;
  flow_mux_pkg::lane_beat_t [`NUM_LANES-1:0] lane_beat;

  // --------------------------------------------------
  // Lane multiplexers
  // --------------------------------------------------
  // Requesters 0 to 3
  flow_mux_rr lane0_mux_i (
    .clk,
    .arst_n,
    .push_valid(push_valid[`FLOWS_PER_LANE-1:0]),
    .push_ready(push_ready[`FLOWS_PER_LANE-1:0]),
    .push_data (push_data[`FLOWS_PER_LANE-1:0]),
    .pop_ready (lane_ready[0]),
    .pop_valid (lane_valid[0]),
    .pop_beat  (lane_beat[0])
  );

  // Requesters 4 to 7
  flow_mux_rr lane1_mux_i (
    .clk,
    .arst_n,
    .push_valid(push_valid[2*`FLOWS_PER_LANE-1:`FLOWS_PER_LANE]),
    .push_ready(push_ready[2*`FLOWS_PER_LANE-1:`FLOWS_PER_LANE]),
    .push_data (push_data[2*`FLOWS_PER_LANE-1:`FLOWS_PER_LANE]),
    .pop_ready (lane_ready[1]),
    .pop_valid (lane_valid[1]),
    .pop_beat  (lane_beat[1])
  );

  // --------------------------------------------------
  // Lane merger and output buffer
  // --------------------------------------------------
  flow_lane_merge merge_i (
    .clk,
    .arst_n,
    .lane_valid,
    .lane_ready,
    .lane_beat,
    .pop_ready,
    .pop_valid,
    .pop_beat
  );

endmodule

`default_nettype wire

// ==== design/flow_mux_cfg.svh ====
// Merger sizing. SRC_W must equal one lane bit plus FLOW_IDX_W and nothing checks it
`ifndef FLOW_MUX_CFG_SVH
`define FLOW_MUX_CFG_SVH

// --------------------------------------------------
// Topology
// --------------------------------------------------
// Requesters served by one lane multiplexer
`define FLOWS_PER_LANE 4
// Lanes feeding the lane merger
`define NUM_LANES 2

// --------------------------------------------------
// Widths
// --------------------------------------------------
`define DATA_WIDTH 16
// Index inside one lane, log2 of FLOWS_PER_LANE
`define FLOW_IDX_W 2
// Global source number with the lane bit on top
`define SRC_W 3

`endif

// ==== design/flow_mux_pkg.sv ====
// Beat and state types for the merger, sized by the config header macros
`default_nettype none

`include "flow_mux_cfg.svh"

package flow_mux_pkg;

  // --------------------------------------------------
  // Beats
  // --------------------------------------------------
  // Beat leaving a lane multiplexer
  typedef struct packed {
    logic [`FLOW_IDX_W-1:0] idx;   // Requester inside the lane
    logic [`DATA_WIDTH-1:0] data;
  } lane_beat_t;

  // Beat on the merged output port
  typedef struct packed {
    logic [`SRC_W-1:0]      src;   // Lane bit above the lane index
    logic [`DATA_WIDTH-1:0] data;
  } out_beat_t;

  // --------------------------------------------------
  // Output buffer
  // --------------------------------------------------
  // Fill level of the two-entry skid buffer
  typedef enum logic [1:0] {
    SKID_EMPTY = 2'd0,
    SKID_ONE   = 2'd1,
    SKID_TWO   = 2'd2
  } skid_state_e;

endpackage

`default_nettype wire

// ==== design/flow_mux_rr.sv ====
// One lane multiplexer with zero latency. FLOWS_PER_LANE must be a power of two
`timescale 1ns/1ps
`default_nettype none

`include "flow_mux_cfg.svh"

module flow_mux_rr (
  input  logic                                           clk,
  input  logic                                           arst_n,
  input  logic [`FLOWS_PER_LANE-1:0]                     push_valid,
  output logic [`FLOWS_PER_LANE-1:0]                     push_ready,
  input  logic [`FLOWS_PER_LANE-1:0][`DATA_WIDTH-1:0]    push_data,
  input  logic                                           pop_ready,
  output logic                                           pop_valid,
  output flow_mux_pkg::lane_beat_t                       pop_beat
);

  logic [`FLOW_IDX_W-1:0] grant_idx;
  logic [`FLOW_IDX_W-1:0] next_idx_q;
  logic [`FLOW_IDX_W-1:0] cand_idx;
  logic [`FLOW_IDX_W-1:0] pick_idx;
  logic                   pick_found;
  logic [`FLOW_IDX_W-1:0] sel_idx;

  flow_arb_rr #(
    .NumFlows(`FLOWS_PER_LANE)
  ) arb_i (
    .clk,
    .arst_n,
    .push_valid,
    .push_ready,
    .pop_ready,
    .pop_valid
  );

  // --------------------------------------------------
  // Index of the winner
  // --------------------------------------------------
  // Ready and valid meet on at most one requester
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < `FLOWS_PER_LANE; i++) begin
      if (push_ready[i] && push_valid[i]) begin
        grant_idx = `FLOW_IDX_W'(i);
      end
    end
  end

  // Tracks the arbiter pointer as a binary index
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      next_idx_q <= '0;
    end else if (pop_valid && pop_ready) begin
      next_idx_q <= `FLOW_IDX_W'(grant_idx + 1'b1);
    end
  end

  // Arbiter's pending choice while ready is low
  // Keeps the beat steady before the consumer accepts it
  always_comb begin
    pick_idx   = next_idx_q;
    pick_found = 1'b0;
    cand_idx   = next_idx_q;
    for (int k = 0; k < `FLOWS_PER_LANE; k++) begin
      cand_idx = `FLOW_IDX_W'(next_idx_q + k);
      if (!pick_found && push_valid[cand_idx]) begin
        pick_idx   = cand_idx;
        pick_found = 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Data path
  // --------------------------------------------------
  assign sel_idx = (pop_valid && pop_ready) ? grant_idx : pick_idx;

  assign pop_beat.idx  = sel_idx;
  assign pop_beat.data = push_data[sel_idx];

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+design
design/flow_mux_pkg.sv
design/flow_arb_rr.sv
design/flow_mux_rr.sv
design/flow_lane_merge.sv
design/flow_merge_top.sv
tests/flow_merge_tb.sv

// ==== tests/flow_merge_input.txt ====
# mask(hex, bit i = requester i) data0 .. data7 (hex, ---- = random) pop_ready, one line per cycle
# A requester still waiting for push_ready keeps its old beat and ignores its column
01 1001 ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
10 ---- ---- ---- ---- 5004 ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
08 ---- ---- ---- 3003 ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
80 ---- ---- ---- ---- ---- ---- ---- 8007 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
ff a000 a001 a002 a003 a004 a005 a006 a007 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 0
ff ---- ---- ---- ---- ---- ---- ---- ---- 0
ff ---- ---- ---- ---- ---- ---- ---- ---- 0
ff ---- ---- ---- ---- ---- ---- ---- ---- 0
ff ---- ---- ---- ---- ---- ---- ---- ---- 0
ff ---- ---- ---- ---- ---- ---- ---- ---- 0
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
ff ---- ---- ---- ---- ---- ---- ---- ---- 1
05 c000 ---- c002 ---- ---- ---- ---- ---- 1
90 ---- ---- ---- ---- d004 ---- ---- d007 1
a3 ---- ---- ---- ---- ---- ---- ---- ---- 0
a3 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 0
00 ---- ---- ---- ---- ---- ---- ---- ---- 0
21 e000 ---- ---- ---- ---- e005 ---- ---- 1
42 ---- e101 ---- ---- ---- ---- e106 ---- 1
84 ---- ---- e202 ---- ---- ---- ---- e207 0
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
18 ---- ---- ---- f003 f004 ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1
00 ---- ---- ---- ---- ---- ---- ---- ---- 1

// ==== tests/flow_merge_tb.sv ====
// Must run from the project root because the stimulus path is relative to it and data lines are fixed-width
`timescale 1ns/1ps
`default_nettype none

`include "flow_mux_cfg.svh"

module flow_merge_tb;

  localparam int NumSrc  = `NUM_LANES * `FLOWS_PER_LANE;
  localparam int LineMax = 64;
  localparam int WaitMax = 8;

  logic                               clk;
  logic                               arst_n;
  logic [NumSrc-1:0]                  push_valid;
  logic [NumSrc-1:0]                  push_ready;
  logic [NumSrc-1:0][`DATA_WIDTH-1:0] push_data;
  logic                               pop_ready;
  logic                               pop_valid;
  flow_mux_pkg::out_beat_t            pop_beat;

  // Stimulus with one entry per data line
  logic [NumSrc-1:0]                  stim_mask[$];
  logic [NumSrc-1:0]                  stim_rand[$];
  logic [NumSrc-1:0][`DATA_WIDTH-1:0] stim_data[$];
  logic                               stim_pop[$];

  // Requester model and scoreboard
  logic [NumSrc-1:0]                  busy;
  logic [NumSrc-1:0][`DATA_WIDTH-1:0] beat_data;
  int                                 wait_cnt[NumSrc];
  logic [`DATA_WIDTH-1:0]             src_q[NumSrc][$];
  int                                 in_flight;
  int                                 errors;
  int                                 n_push;
  int                                 n_pop;

  // Checker state
  logic                               first_after_reset;
  logic                               hold_pending;
  flow_mux_pkg::out_beat_t            held_beat;
  logic                               expect_pop;
  flow_mux_pkg::out_beat_t            expect_beat;
  int                                 bp_pushes;
  int                                 full_run;
  int                                 win_src[NumSrc];
  int                                 win_pos;
  int                                 line_idx;
  int                                 cycle;
  int                                 limit;
  logic                               timed_out;
  logic                               finished;

  flow_merge_top dut_i (
    .clk,
    .arst_n,
    .push_valid,
    .push_ready,
    .push_data,
    .pop_ready,
    .pop_valid,
    .pop_beat
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic flag_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic note_problem(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  function automatic logic [3:0] hex_nibble(input logic [7:0] ch);
    logic [3:0] val;
    val = 4'h0;
    if (ch >= "0" && ch <= "9") begin
      val = 4'(ch - "0");
    end else if (ch >= "a" && ch <= "f") begin
      val = 4'(ch - "a" + 8'd10);
    end else if (ch >= "A" && ch <= "F") begin
      val = 4'(ch - "A" + 8'd10);
    end
    return val;
  endfunction

  // Text from $fgets sits right-aligned so position 0 is the first character
  function automatic logic [7:0] char_at(input logic [8*LineMax-1:0] text,
                                         input int len, input int pos);
    return text[8*(len-1-pos) +: 8];
  endfunction

  function automatic logic [15:0] hex_field(input logic [8*LineMax-1:0] text,
                                            input int len, input int pos, input int ndig);
    logic [15:0] val;
    val = '0;
    for (int k = 0; k < ndig; k++) begin
      val = {val[11:0], hex_nibble(char_at(text, len, pos + k))};
    end
    return val;
  endfunction

  // --------------------------------------------------
  // Stimulus file
  // --------------------------------------------------
  // Mask at column 0, word i at 3+5*i and pop_ready at 43
  task automatic load_stimulus();
    int                                 fd;
    int                                 len;
    logic [8*LineMax-1:0]               text;
    logic [NumSrc-1:0]                  rnd;
    logic [NumSrc-1:0][`DATA_WIDTH-1:0] words;
    fd = $fopen("tests/flow_merge_input.txt", "r");
    if (fd == 0) begin
      note_problem("Could not open the stimulus file tests/flow_merge_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      text = '0;
      len  = $fgets(text, fd);
      // Comments and short lines carry no cycle
      if (len >= 44 && char_at(text, len, 0) != "#") begin
        for (int i = 0; i < NumSrc; i++) begin
          rnd[i]   = (char_at(text, len, 3 + 5*i) == "-");
          words[i] = hex_field(text, len, 3 + 5*i, 4);
        end
        stim_mask.push_back(NumSrc'(hex_field(text, len, 0, 2)));
        stim_rand.push_back(rnd);
        stim_data.push_back(words);
        stim_pop.push_back(char_at(text, len, 43) == "1");
      end
    end
    $fclose(fd);
  endtask

  // On the falling edge idle requesters pick up new mask bits
  task automatic drive_inputs();
    if (line_idx < stim_mask.size()) begin
      for (int i = 0; i < NumSrc; i++) begin
        if (!busy[i] && stim_mask[line_idx][i]) begin
          busy[i]     = 1'b1;
          wait_cnt[i] = 0;
          if (stim_rand[line_idx][i]) begin
            beat_data[i] = `DATA_WIDTH'($urandom);
          end else begin
            beat_data[i] = stim_data[line_idx][i];
          end
        end
      end
      pop_ready = stim_pop[line_idx];
      line_idx++;
    end else begin
      // Drain phase
      pop_ready = 1'b1;
    end
    push_valid = busy;
    push_data  = beat_data;
  endtask

  // --------------------------------------------------
  // Checks sampled 1 ns before the rising edge
  // --------------------------------------------------
  task automatic sample_and_check();
    logic [NumSrc-1:0]      fire;
    logic [NumSrc-1:0]      seen;
    logic                   was_empty;
    logic [`DATA_WIDTH-1:0] want;
    int                     src;
    int                     tag;
    int                     nfire;
    fire      = push_valid & push_ready;
    nfire     = $countones(fire);
    was_empty = (in_flight == 0);

    if ($countones(push_ready[`FLOWS_PER_LANE-1:0]) > 1 ||
        $countones(push_ready[NumSrc-1:`FLOWS_PER_LANE]) > 1) begin
      flag_error($sformatf("push_ready %b grants twice in one lane", push_ready));
    end
    if (first_after_reset && pop_valid) begin
      flag_error("pop_valid high in the first cycle after reset");
    end
    first_after_reset = 1'b0;
    // Stalled output stays put
    if (hold_pending && (!pop_valid || pop_beat != held_beat)) begin
      flag_error($sformatf("stalled beat %h changed to %h", held_beat, pop_beat));
    end
    if (expect_pop && (!pop_valid || pop_beat != expect_beat)) begin
      flag_error($sformatf("beat %h missing one cycle after its push", expect_beat));
    end
    expect_pop = 1'b0;

    if (pop_valid && pop_ready) begin
      src = int'(pop_beat.src);
      n_pop++;
      in_flight--;
      if (src_q[src].size() == 0) begin
        flag_error($sformatf("pop tagged source %0d with nothing pending", src));
      end else begin
        want = src_q[src].pop_front();
        if (pop_beat.data != want) begin
          flag_error($sformatf("source %0d popped %h, expected %h", src, pop_beat.data, want));
        end
      end
    end

    for (int i = 0; i < NumSrc; i++) begin
      if (fire[i]) begin
        // Source number is lane times four plus lane index
        tag = (i / `FLOWS_PER_LANE) * 4 + (i % `FLOWS_PER_LANE);
        src_q[tag].push_back(beat_data[i]);
        busy[i] = 1'b0;
        n_push++;
        in_flight++;
        if (was_empty && pop_ready && nfire == 1) begin
          expect_pop       = 1'b1;
          expect_beat.src  = `SRC_W'(tag);
          expect_beat.data = beat_data[i];
        end
        full_run        = (push_valid == '1) ? full_run + 1 : 0;
        win_src[win_pos] = tag;
        win_pos         = (win_pos + 1) % NumSrc;
      end else if (busy[i]) begin
        wait_cnt[i] += nfire;
        if (wait_cnt[i] > WaitMax && wait_cnt[i] - nfire <= WaitMax) begin
          flag_error($sformatf("source %0d waited past %0d transfers", i, WaitMax));
        end
      end
    end

    // Under full load the last eight transfers cover every source
    if (nfire != 0 && full_run >= NumSrc) begin
      seen = '0;
      for (int k = 0; k < NumSrc; k++) begin
        seen[win_src[k]] = 1'b1;
      end
      if (seen != '1) begin
        flag_error($sformatf("eight transfers under full load cover only %b", seen));
      end
    end

    if (!pop_ready) begin
      bp_pushes += nfire;
      if (bp_pushes > 2 && nfire != 0) begin
        flag_error($sformatf("push %0d accepted while pop_ready is low", bp_pushes));
      end
    end else begin
      bp_pushes = 0;
    end
    hold_pending = pop_valid && !pop_ready;
    held_beat    = pop_beat;
  endtask

  task automatic finish_run();
    if (timed_out) begin
      note_problem($sformatf("Run hit the %0d cycle limit before draining", limit));
    end
    for (int i = 0; i < NumSrc; i++) begin
      if (src_q[i].size() != 0) begin
        note_problem($sformatf("Source %0d still has %0d beats that never left", i,
                               src_q[i].size()));
      end
    end
    if (busy != '0) begin
      note_problem($sformatf("Requesters %b never saw push_ready", busy));
    end
    $display("Summary: %0d errors, %0d pushes, %0d pops", errors, n_push, n_pop);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    void'($urandom(32'hd251));
    arst_n     = 1'b0;
    pop_ready  = 1'b0;
    push_valid = '1;
    push_data  = '0;
    busy       = '0;
    beat_data  = '0;
    in_flight  = 0;
    errors     = 0;
    n_push     = 0;
    n_pop      = 0;
    hold_pending = 1'b0;
    held_beat  = '0;
    expect_pop = 1'b0;
    expect_beat = '0;
    bp_pushes  = 0;
    full_run   = 0;
    win_pos    = 0;
    line_idx   = 0;
    cycle      = 0;
    timed_out  = 1'b0;
    finished   = 1'b0;
    for (int i = 0; i < NumSrc; i++) begin
      wait_cnt[i] = 0;
      win_src[i]  = 0;
    end
    load_stimulus();
    limit = stim_mask.size() + 200;

    // Requests stay up during reset and none may be granted
    repeat (5) begin
      @(negedge clk);
      if (pop_valid !== 1'b0 || push_ready !== '0) begin
        flag_error("pop_valid or push_ready active during reset");
      end
    end
    arst_n = 1'b1;
    first_after_reset = 1'b1;

    while (!finished && !timed_out) begin
      drive_inputs();
      #1;
      sample_and_check();
      cycle++;
      if (line_idx >= stim_mask.size() && busy == '0 && in_flight == 0) begin
        finished = 1'b1;
      end else if (cycle >= limit) begin
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    finish_run();
  end

endmodule

`default_nettype wire
